// ==== verilog/periph_pkg.sv ====
package periph_pkg;

  ////////////////////
  // I/O port map
  ////////////////////
  localparam logic [15:0] port_kempston = 16'h001F;  // Low byte decoded only
  localparam logic [15:0] port_reg_addr = 16'hFC3B;  // Register number
  localparam logic [15:0] port_reg_data = 16'hFD3B;  // Register data
  localparam logic [7:0]  port_ula      = 8'hFE;     // Any even port hits

  // Extended register numbers
  typedef enum logic [7:0] {
    reg_spi_ctrl    = 8'h02,  // Chip selects, busy in bit 7
    reg_spi_data    = 8'h03,  // Shift register
    reg_audio_level = 8'h04   // Tone level
  } ext_reg_e;

  ////////////////////
  // Mixer weights
  ////////////////////
  // Worst case 96 + 32 + 32 + 63 = 223, fits in 8 bits
  localparam logic [7:0] mix_w_spk = 8'd96;
  localparam logic [7:0] mix_w_mic = 8'd32;
  localparam logic [7:0] mix_w_ear = 8'd32;

  // SPI master states
  typedef enum logic [1:0] {
    spi_idle,
    spi_shift,
    spi_done
  } spi_state_e;

  ////////////////////
  // Bus structs
  ////////////////////
  typedef struct packed {
    logic        strobe;  // One cycle per access
    logic        write;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } io_req_t;

  typedef struct packed {
    logic       valid;  // One cycle after read strobe
    logic [7:0] rdata;
  } io_rsp_t;

  // Register window strobe, one cycle per data-port access
  typedef struct packed {
    logic       rd;
    logic       wr;
    ext_reg_e   sel;
    logic [7:0] wdata;
  } ext_reg_t;

  typedef struct packed {
    logic       oe;    // Source drives the read bus
    logic [7:0] data;
  } rd_src_t;

endpackage

// ==== verilog/ext_reg_port.sv ====
`timescale 1ns/1ps

// Indirect register window at FC3B (number) and FD3B (data)
module ext_reg_port (
  input  logic                 clk,
  input  logic                 reset,
  input  periph_pkg::io_req_t  io_req,
  output periph_pkg::ext_reg_t ext_reg,
  output periph_pkg::rd_src_t  rd_src
);

  periph_pkg::ext_reg_e reg_num;  // Currently selected register

  logic addr_hit;  // Access to number port
  logic data_hit;  // Access to data port

  ////////////////////
  // Port decode
  ////////////////////
  // Full 16-bit compare on both ports
  assign addr_hit = io_req.strobe && (io_req.addr == periph_pkg::port_reg_addr);
  assign data_hit = io_req.strobe && (io_req.addr == periph_pkg::port_reg_data);

  // Register number latch
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_num <= periph_pkg::ext_reg_e'(8'h00);  // Register 0 after reset
    end else if (addr_hit && io_req.write) begin
      reg_num <= periph_pkg::ext_reg_e'(io_req.wdata);
    end
  end

  ////////////////////
  // Register strobes
  ////////////////////
  // Combinational, lives only in the request cycle
  always_comb begin
    ext_reg.rd    = data_hit && !io_req.write;
    ext_reg.wr    = data_hit && io_req.write;
    ext_reg.sel   = reg_num;       // Peripherals match their own numbers
    ext_reg.wdata = io_req.wdata;
  end

  // Readback of the selected number
  always_comb begin
    rd_src.oe   = addr_hit && !io_req.write;
    rd_src.data = reg_num;
  end

endmodule

// ==== verilog/spi_bridge.sv ====
`timescale 1ns/1ps

// SPI master for flash and SD, mode 0, sclk at half clk
module spi_bridge (
  input  logic                 clk,
  input  logic                 reset,
  input  periph_pkg::ext_reg_t ext_reg,
  output periph_pkg::rd_src_t  rd_src,
  output logic                 flash_cs_n,
  output logic                 sd_cs_n,
  output logic                 spi_sclk,
  output logic                 spi_mosi,
  input  logic                 flash_miso,
  input  logic                 sd_miso
);

  periph_pkg::spi_state_e state;

  logic [1:0] cs_q;       // Bit 0 flash, bit 1 SD, active low
  logic       sclk_q;
  logic [2:0] bit_cnt;    // Counts falling sclk edges
  logic [7:0] shift_out;
  logic [7:0] shift_in;
  logic [7:0] rx_byte;    // Last received byte
  logic       busy;
  logic       miso;
  logic       ctrl_hit;
  logic       data_hit;
  logic       start;
  logic [7:0] tx_byte;
  logic [1:0] cs_next;

  ////////////////////
  // Register decode
  ////////////////////
  assign ctrl_hit = ext_reg.sel == periph_pkg::reg_spi_ctrl;
  assign data_hit = ext_reg.sel == periph_pkg::reg_spi_data;

  assign start   = data_hit && (ext_reg.rd || ext_reg.wr);  // Read or write kicks off
  assign tx_byte = ext_reg.wr ? ext_reg.wdata : 8'hFF;      // Dummy byte on read

  // Both selects low -> flash keeps it, SD dropped
  assign cs_next = (ext_reg.wdata[1:0] == 2'b00) ? 2'b10 : ext_reg.wdata[1:0];

  assign busy = state != periph_pkg::spi_idle;              // Shift and done
  assign miso = cs_q[0] ? sd_miso : flash_miso;

  // Control state and FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= periph_pkg::spi_idle;
      cs_q      <= 2'b11;  // Nothing selected
      sclk_q    <= 1'b0;
      bit_cnt   <= 3'd0;
      shift_out <= 8'h00;  // Keeps mosi low
    end else begin
      if (ext_reg.wr && ctrl_hit) begin
        cs_q <= cs_next;
      end
      case (state)
        periph_pkg::spi_idle: begin
          if (start) begin  // Ignored when busy
            state     <= periph_pkg::spi_shift;
            shift_out <= tx_byte;  // MSB shows on mosi right away
            bit_cnt   <= 3'd0;
          end
        end
        periph_pkg::spi_shift: begin
          sclk_q <= ~sclk_q;
          if (sclk_q) begin  // Falling sclk, next mosi bit
            shift_out <= {shift_out[6:0], 1'b0};
            bit_cnt   <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= periph_pkg::spi_done;
            end
          end
        end
        periph_pkg::spi_done: state <= periph_pkg::spi_idle;  // One cycle only
        default:              state <= periph_pkg::spi_idle;
      endcase
    end
  end

  ////////////////////
  // Receive path
  ////////////////////
  always_ff @(posedge clk) begin
    if (state == periph_pkg::spi_shift) begin
      if (!sclk_q) begin
        shift_in <= {shift_in[6:0], miso};  // Rising sclk samples
      end else if (bit_cnt == 3'd7) begin
        rx_byte <= shift_in;                // All 8 bits in
      end
    end
  end

  // Readback
  always_comb begin
    rd_src.oe   = ext_reg.rd && (ctrl_hit || data_hit);
    rd_src.data = ctrl_hit ? {busy, 5'b00000, cs_q} : rx_byte;
  end

  // Pins
  assign flash_cs_n = cs_q[0];
  assign sd_cs_n    = cs_q[1];
  assign spi_sclk   = sclk_q;
  assign spi_mosi   = shift_out[7];

endmodule

// ==== verilog/audio_mixer.sv ====
`timescale 1ns/1ps

// Beeper, mic, ear and tone level mixed into a 1-bit sigma-delta stream
module audio_mixer (
  input  logic                 clk,
  input  logic                 reset,
  input  periph_pkg::io_req_t  io_req,
  input  periph_pkg::ext_reg_t ext_reg,
  input  logic                 ear,
  output logic                 audio_out
);

  logic       spk;
  logic       mic;
  logic [7:0] level;
  logic [1:0] ear_sync;   // Two-flop synchronizer
  logic [7:0] mix;
  logic [7:0] acc;
  logic [8:0] acc_sum;    // Carry in bit 8
  logic       ula_wr;
  logic       level_wr;

  ////////////////////
  // Source latches
  ////////////////////
  // Beeper port decodes on A0 alone
  assign ula_wr   = io_req.strobe && io_req.write &&
                    (io_req.addr[0] == periph_pkg::port_ula[0]);
  assign level_wr = ext_reg.wr && (ext_reg.sel == periph_pkg::reg_audio_level);

  always_ff @(posedge clk) begin
    if (reset) begin
      spk   <= 1'b0;
      mic   <= 1'b0;
      level <= 8'h00;
    end else begin
      if (ula_wr) begin
        spk <= io_req.wdata[4];  // Bit 4 beeper
        mic <= io_req.wdata[3];  // Bit 3 mic
      end
      if (level_wr) level <= ext_reg.wdata;
    end
  end

  always_ff @(posedge clk) begin
    ear_sync <= {ear_sync[0], ear};
  end

  // Weighted sum, max 223
  assign mix = (spk ? periph_pkg::mix_w_spk : 8'd0) +
               (mic ? periph_pkg::mix_w_mic : 8'd0) +
               (ear_sync[1] ? periph_pkg::mix_w_ear : 8'd0) +
               {2'b00, level[7:2]};  // Level / 4

  ////////////////////
  // Sigma-delta
  ////////////////////
  assign acc_sum = {1'b0, acc} + {1'b0, mix};

  always_ff @(posedge clk) begin
    if (reset || ula_wr || level_wr) begin
      acc       <= 8'h00;  // Restart so 256 cycles give exactly mix ones
      audio_out <= 1'b0;
    end else begin
      acc       <= acc_sum[7:0];
      audio_out <= acc_sum[8];  // Carry is the output bit
    end
  end

endmodule

// ==== verilog/cpu_bus_mux.sv ====
`timescale 1ns/1ps

// Kempston port and registered read-data priority mux
module cpu_bus_mux (
  input  logic                clk,
  input  logic                reset,
  input  periph_pkg::io_req_t io_req,
  input  logic [4:0]          joy,
  input  periph_pkg::rd_src_t reg_src,
  input  periph_pkg::rd_src_t spi_src,
  output periph_pkg::io_rsp_t io_rsp
);

  logic [4:0] joy_meta;
  logic [4:0] joy_sync;    // Readable two cycles after a change
  logic       rd_strobe;
  logic       kemp_oe;
  logic [7:0] rd_data;
  logic       rsp_valid;
  logic [7:0] rsp_rdata;

  ////////////////////
  // Kempston joystick
  ////////////////////
  always_ff @(posedge clk) begin
    joy_meta <= joy;
    joy_sync <= joy_meta;
  end

  assign rd_strobe = io_req.strobe && !io_req.write;
  // Only the low address byte is decoded
  assign kemp_oe   = rd_strobe && (io_req.addr[7:0] == periph_pkg::port_kempston[7:0]);

  // Priority: window, SPI, joystick, then open bus
  always_comb begin
    if (reg_src.oe)      rd_data = reg_src.data;
    else if (spi_src.oe) rd_data = spi_src.data;
    else if (kemp_oe)    rd_data = {3'b000, joy_sync};  // Top bits read 0
    else                 rd_data = 8'hFF;
  end

  ////////////////////
  // Response register
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) rsp_valid <= 1'b0;
    else       rsp_valid <= rd_strobe;  // Fixed one-cycle latency
  end

  always_ff @(posedge clk) begin
    if (rd_strobe) rsp_rdata <= rd_data;
  end

  assign io_rsp.valid = rsp_valid;
  assign io_rsp.rdata = rsp_rdata;

endmodule

// ==== verilog/periph_top.sv ====
`timescale 1ns/1ps

// I/O subsystem top, CPU bus in, pins out
module periph_top (
  input  logic                clk,
  input  logic                reset,

  // CPU side
  input  periph_pkg::io_req_t io_req,
  output periph_pkg::io_rsp_t io_rsp,

  // Joystick and audio
  input  logic [4:0]          joy,
  input  logic                ear,
  output logic                audio_out,

  // SPI, shared clock and data
  output logic                flash_cs_n,
  output logic                sd_cs_n,
  output logic                spi_sclk,
  output logic                spi_mosi,
  input  logic                flash_miso,
  input  logic                sd_miso
);

  periph_pkg::ext_reg_t ext_reg;  // Window strobes to peripherals
  periph_pkg::rd_src_t  reg_src;  // Register number readback
  periph_pkg::rd_src_t  spi_src;  // SPI status and data readback

  ////////////////////
  // Register window
  ////////////////////
  ext_reg_port u_ext_reg_port (
    .clk    (clk),
    .reset  (reset),
    .io_req (io_req),
    .ext_reg(ext_reg),
    .rd_src (reg_src)
  );

  // Flash and SD
  spi_bridge u_spi_bridge (
    .clk       (clk),
    .reset     (reset),
    .ext_reg   (ext_reg),
    .rd_src    (spi_src),
    .flash_cs_n(flash_cs_n),
    .sd_cs_n   (sd_cs_n),
    .spi_sclk  (spi_sclk),
    .spi_mosi  (spi_mosi),
    .flash_miso(flash_miso),
    .sd_miso   (sd_miso)
  );

  ////////////////////
  // Sound
  ////////////////////
  audio_mixer u_audio_mixer (
    .clk      (clk),
    .reset    (reset),
    .io_req   (io_req),
    .ext_reg  (ext_reg),
    .ear      (ear),
    .audio_out(audio_out)
  );

  // Read mux and Kempston port
  cpu_bus_mux u_cpu_bus_mux (
    .clk    (clk),
    .reset  (reset),
    .io_req (io_req),
    .joy    (joy),
    .reg_src(reg_src),
    .spi_src(spi_src),
    .io_rsp (io_rsp)
  );

endmodule

// ==== testbench/periph_assert.sv ====
`timescale 1ns/1ps

// Bus latency and SPI pin rules, bound into periph_top
module periph_assert (
  input logic                clk,
  input logic                reset,
  input periph_pkg::io_req_t io_req,
  input periph_pkg::io_rsp_t io_rsp,
  input logic                flash_cs_n,
  input logic                sd_cs_n,
  input logic                spi_sclk
);

  int   fail_count = 0;  // Read by the testbench
  logic rd_strobe;

  assign rd_strobe = io_req.strobe && !io_req.write;

  ////////////////////
  // CPU bus
  ////////////////////
  rsp_after_read: assert property (@(posedge clk) disable iff (reset)
    rd_strobe |=> io_rsp.valid)
    else begin
      $error("read strobe got no response one cycle later");
      fail_count++;
    end

  // No response without a read
  no_stray_rsp: assert property (@(posedge clk) disable iff (reset)
    !rd_strobe |=> !io_rsp.valid)
    else begin
      $error("response valid without a read strobe");
      fail_count++;
    end

  ////////////////////
  // SPI pins
  ////////////////////
  cs_exclusive: assert property (@(posedge clk) disable iff (reset)
    flash_cs_n || sd_cs_n)  // Flash and SD never both selected
    else begin
      $error("flash and SD chip selects low together");
      fail_count++;
    end

  sclk_idle: assert property (@(posedge clk) disable iff (reset)
    (flash_cs_n && sd_cs_n) |-> !spi_sclk)
    else begin
      $error("sclk high with no device selected");
      fail_count++;
    end

endmodule

bind periph_top periph_assert u_periph_assert (
  .clk       (clk),
  .reset     (reset),
  .io_req    (io_req),
  .io_rsp    (io_rsp),
  .flash_cs_n(flash_cs_n),
  .sd_cs_n   (sd_cs_n),
  .spi_sclk  (spi_sclk)
);

// ==== testbench/periph_tb.sv ====
`timescale 1ns/1ps

module periph_tb;

  logic                clk;
  logic                reset;
  periph_pkg::io_req_t io_req;
  periph_pkg::io_rsp_t io_rsp;
  logic [4:0]          joy;
  logic                ear;
  logic                audio_out;
  logic                flash_cs_n;
  logic                sd_cs_n;
  logic                spi_sclk;
  logic                spi_mosi;
  logic                flash_miso;
  logic                sd_miso;

  integer     seed = 13585;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         errors_at_start = 0;
  logic [7:0] slave_byte;          // Byte the SPI slave returns
  logic [7:0] mosi_rx;             // Last 8 mosi bits, MSB first
  logic [2:0] miso_idx = 3'd0;     // Falling sclk edges, wraps per byte

  periph_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  ////////////////////
  // SPI slave model
  ////////////////////
  // Deselected device drives the inverted bit, so a wrong miso mux shows up
  assign flash_miso = flash_cs_n ^ slave_byte[~miso_idx];
  assign sd_miso    = sd_cs_n ^ slave_byte[~miso_idx];

  always @(negedge spi_sclk) if (!reset) miso_idx <= miso_idx + 3'd1;
  always @(posedge spi_sclk) mosi_rx <= {mosi_rx[6:0], spi_mosi};  // Master sends on fall

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  function automatic int total_errors();
    return errors + UUT.u_periph_assert.fail_count;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() != errors_at_start) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    errors_at_start = total_errors();
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////
  // CPU bus tasks
  ////////////////////
  // Entered and left 1 ns after a rising edge
  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    io_req = '{strobe: 1'b1, write: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    #1;
    io_req.strobe = 1'b0;  // One-cycle strobe
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
    int n;
    n = 0;
    io_req = '{strobe: 1'b1, write: 1'b0, addr: addr, wdata: 8'h00};
    @(posedge clk);
    #1;
    io_req.strobe = 1'b0;
    while (!io_rsp.valid) begin
      if (n == 8) abort_run("no read response from the DUT");
      @(posedge clk);
      #1;
      n++;
    end
    data = io_rsp.rdata;
  endtask

  task automatic reg_write(input logic [7:0] num, input logic [7:0] data);
    bus_write(periph_pkg::port_reg_addr, num);
    bus_write(periph_pkg::port_reg_data, data);
  endtask

  task automatic reg_read(input logic [7:0] num, output logic [7:0] data);
    bus_write(periph_pkg::port_reg_addr, num);
    bus_read(periph_pkg::port_reg_data, data);
  endtask

  // Poll busy in bit 7 of the SPI control register
  task automatic wait_spi_idle();
    logic [7:0] ctrl;
    int n;
    n = 0;
    reg_read(periph_pkg::reg_spi_ctrl, ctrl);
    while (ctrl[7]) begin
      if (n == 40) abort_run("SPI busy flag never cleared");
      reg_read(periph_pkg::reg_spi_ctrl, ctrl);
      n++;
    end
  endtask

  // Ones over 256 cycles after the accumulator clear equal the mix
  task automatic audio_case(input logic spk, input logic mic, input logic ear_v, input int lvl);
    int ones;
    int expected;
    ones = 0;
    expected = lvl / 4;
    if (spk) expected = expected + 96;
    if (mic) expected = expected + 32;
    if (ear_v) expected = expected + 32;
    ear = ear_v;
    wait_cycles(3);  // Through the ear synchronizer
    bus_write(16'h00FE, {3'b000, spk, mic, 3'b000});
    reg_write(periph_pkg::reg_audio_level, lvl[7:0]);  // Last write clears the accumulator
    for (int i = 0; i < 256; i++) begin
      @(posedge clk);
      #1;
      if (audio_out) ones++;
    end
    check_byte("audio_out ones", ones[7:0], expected[7:0]);
  endtask

  initial begin
    logic [7:0] v;
    logic [7:0] tx;
    int         rnd;
    reset      = 1'b1;
    io_req     = '0;
    joy        = 5'd0;
    ear        = 1'b0;
    slave_byte = 8'h00;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset values
    check_bit("flash_cs_n", flash_cs_n, 1'b1);
    check_bit("sd_cs_n", sd_cs_n, 1'b1);
    check_bit("spi_sclk", spi_sclk, 1'b0);
    check_bit("spi_mosi", spi_mosi, 1'b0);
    check_bit("audio_out", audio_out, 1'b0);
    check_bit("io_rsp.valid", io_rsp.valid, 1'b0);
    bus_read(periph_pkg::port_reg_addr, v);
    check_byte("reg number", v, 8'h00);
    end_test("reset values");

    // Register window and open bus
    bus_write(periph_pkg::port_reg_addr, 8'h04);
    bus_read(periph_pkg::port_reg_addr, v);
    check_byte("reg number", v, 8'h04);
    bus_read(16'h7FFD, v);
    check_byte("open bus rdata", v, 8'hFF);
    bus_read(periph_pkg::port_reg_data, v);  // Level register, no readback
    check_byte("level rdata", v, 8'hFF);
    end_test("register window");

    ////////////////////
    // SPI transfers
    ////////////////////
    rnd = $random(seed);
    tx = rnd[7:0];
    rnd = $random(seed);
    slave_byte = rnd[7:0];
    reg_write(periph_pkg::reg_spi_ctrl, 8'h02);  // Flash selected
    check_bit("flash_cs_n", flash_cs_n, 1'b0);
    check_bit("sd_cs_n", sd_cs_n, 1'b1);
    reg_read(periph_pkg::reg_spi_ctrl, v);
    check_byte("spi ctrl", v, 8'h02);
    reg_write(periph_pkg::reg_spi_data, tx);
    wait_spi_idle();
    check_byte("mosi byte", mosi_rx, tx);
    reg_read(periph_pkg::reg_spi_data, v);
    check_byte("flash rx byte", v, slave_byte);
    wait_spi_idle();  // Readback started a dummy transfer
    end_test("flash transfer");

    rnd = $random(seed);
    slave_byte = rnd[7:0];
    reg_write(periph_pkg::reg_spi_ctrl, 8'h01);  // SD selected
    check_bit("flash_cs_n", flash_cs_n, 1'b1);
    check_bit("sd_cs_n", sd_cs_n, 1'b0);
    reg_read(periph_pkg::reg_spi_data, v);       // Old byte, starts 0xFF transfer
    wait_spi_idle();
    check_byte("mosi byte", mosi_rx, 8'hFF);
    reg_read(periph_pkg::reg_spi_data, v);
    check_byte("sd rx byte", v, slave_byte);
    wait_spi_idle();
    reg_write(periph_pkg::reg_spi_ctrl, 8'h00);  // Both low, flash wins
    check_bit("flash_cs_n", flash_cs_n, 1'b0);
    check_bit("sd_cs_n", sd_cs_n, 1'b1);
    reg_write(periph_pkg::reg_spi_ctrl, 8'h03);
    end_test("sd transfer");

    // Kempston, upper address byte is ignored
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      joy = rnd[4:0];
      wait_cycles(2);
      bus_read({rnd[15:8], 8'h1F}, v);
      check_byte("kempston rdata", v, {3'b000, rnd[4:0]});
    end
    end_test("kempston");

    ////////////////////
    // Audio
    ////////////////////
    rnd = $random(seed);
    audio_case(1'b1, 1'b1, 1'b1, rnd & 255);
    rnd = $random(seed);
    audio_case(1'b1, 1'b0, 1'b0, rnd & 255);
    audio_case(1'b0, 1'b1, 1'b1, 255);
    end_test("audio");

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/periph_pkg.sv
verilog/ext_reg_port.sv
verilog/spi_bridge.sv
verilog/audio_mixer.sv
verilog/cpu_bus_mux.sv
verilog/periph_top.sv
testbench/periph_assert.sv
testbench/periph_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = periph_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
